// ==== Bender.yml ====
package:
  name: gpuCore

sources:
  # design, packages first
  - hw/gpuIsaPkg.sv
  - hw/gpuVideoPkg.sv
  - hw/gpuMcuRegs.sv
  - hw/gpuSequencer.sv
  - hw/gpuExecUnit.sv
  - hw/gpuPixelMixer.sv
  - hw/gpuCore.sv

  # testbench
  - target: test
    files:
      - tb/gpuCore_checker.sv
      - tb/gpuCoreTb.sv

// ==== gpuCore.f ====
hw/gpuIsaPkg.sv
hw/gpuVideoPkg.sv
hw/gpuMcuRegs.sv
hw/gpuSequencer.sv
hw/gpuExecUnit.sv
hw/gpuPixelMixer.sv
hw/gpuCore.sv
tb/gpuCore_checker.sv
tb/gpuCoreTb.sv

// ==== hw/gpuCore.sv ====
`default_nettype none

module gpuCore
(
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 mcuWe,
  input  wire gpuVideoPkg::regSelT  mcuRegSel,
  input  wire logic [7:0]           mcuWriteData,
  input  wire logic [7:0]           vmemData,      // sampled when a uop selects it
  output gpuIsaPkg::wordT           mcuAddr,
  output logic                      mcuReadRequest,
  output logic                      fbWe,
  output gpuVideoPkg::fbAddrT       fbAddr,
  output gpuVideoPkg::fbWordT       fbData
);

  gpuVideoPkg::mcuWriteT  mcuWrite;
  gpuVideoPkg::dispRegsT  dispRegs;
  gpuVideoPkg::tileBytesT tileBytes;
  gpuIsaPkg::uopFieldsT   uop;
  gpuIsaPkg::pcT          jumpTarget;
  logic                   gpuActive;
  logic                   jump;
  logic                   fbWrite;
  logic                   fbAdvance;

  assign mcuWrite = '{we: mcuWe, regSel: mcuRegSel, data: mcuWriteData};

  //////////////////////////////
  // blocks
  //////////////////////////////

  gpuMcuRegs mcuRegs
  (
    .clock     (clock),
    .reset     (reset),
    .mcuWrite  (mcuWrite),
    .dispRegs  (dispRegs),
    .gpuActive (gpuActive)
  );

  gpuSequencer sequencer
  (
    .clock      (clock),
    .reset      (reset),
    .gpuActive  (gpuActive),
    .jump       (jump),
    .jumpTarget (jumpTarget),
    .uop        (uop)
  );

  gpuExecUnit execUnit
  (
    .clock          (clock),
    .reset          (reset),
    .uop            (uop),
    .dispRegs       (dispRegs),
    .vmemData       (vmemData),
    .jump           (jump),
    .jumpTarget     (jumpTarget),
    .tileBytes      (tileBytes),
    .mcuAddr        (mcuAddr),
    .mcuReadRequest (mcuReadRequest),
    .fbWrite        (fbWrite),
    .fbAdvance      (fbAdvance)
  );

  gpuPixelMixer pixelMixer
  (
    .clock     (clock),
    .reset     (reset),
    .gpuActive (gpuActive),
    .dispRegs  (dispRegs),
    .tileBytes (tileBytes),
    .fbWrite   (fbWrite),
    .fbAdvance (fbAdvance),
    .fbWe      (fbWe),
    .fbAddr    (fbAddr),
    .fbData    (fbData)
  );

endmodule

`default_nettype wire

// ==== hw/gpuExecUnit.sv ====
`default_nettype none

module gpuExecUnit
(
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire gpuIsaPkg::uopFieldsT  uop,
  input  wire gpuVideoPkg::dispRegsT dispRegs,
  input  wire logic [7:0]            vmemData,
  output logic                       jump,
  output gpuIsaPkg::pcT              jumpTarget,
  output gpuVideoPkg::tileBytesT     tileBytes,
  output gpuIsaPkg::wordT            mcuAddr,
  output logic                       mcuReadRequest,
  output logic                       fbWrite,
  output logic                       fbAdvance
);

  logic              active;
  logic              zeroFlag;
  logic              aluOp;     // op produces a result
  logic              readReq;
  gpuIsaPkg::wordT   gpr [4];   // R0..R3
  gpuIsaPkg::srcSelT src0Sel;
  gpuIsaPkg::wordT   src1Val;
  gpuIsaPkg::wordT   src0Val;
  gpuIsaPkg::wordT   dstVal;
  gpuIsaPkg::wordT   result;
  gpuIsaPkg::wordT   tileBase;
  gpuIsaPkg::wordT   scrollTile;

  assign active  = dispRegs.lcdc[gpuVideoPkg::LcdcEnableBit];
  assign src0Sel = uop.lit[9:5]; // src0 shares bits with the literal

  //////////////////////////////
  // constant sources
  //////////////////////////////

  // bit 7 of the tile number picks the 8000 half
  assign tileBase = dispRegs.lcdc[gpuVideoPkg::LcdcTileBit] ? gpuVideoPkg::TileBaseShared :
                    (vmemData[7] ? gpuVideoPkg::TileBase1 : gpuVideoPkg::TileBase0);

  // tile index under the scroll origin
  assign scrollTile = {6'b0, dispRegs.scy[7:3], 5'b0} + {8'b0, dispRegs.scx};

  // one operand port for all three reads
  function automatic gpuIsaPkg::wordT srcValue(gpuIsaPkg::srcSelT sel);
    case (sel)
      {1'b0, gpuVideoPkg::RegLcdc}: return {8'b0, dispRegs.lcdc};
      {1'b0, gpuVideoPkg::RegScy}:  return {8'b0, dispRegs.scy};
      {1'b0, gpuVideoPkg::RegScx}:  return {8'b0, dispRegs.scx};
      {1'b0, gpuVideoPkg::RegBgp}:  return {8'b0, dispRegs.bgp};
      {1'b0, gpuVideoPkg::RegObp0}: return {8'b0, dispRegs.obp0};
      {1'b0, gpuVideoPkg::RegObp1}: return {8'b0, dispRegs.obp1};
      gpuIsaPkg::SrcMcuAddr:        return mcuAddr;
      gpuIsaPkg::SrcBh:             return {8'b0, tileBytes.bh};
      gpuIsaPkg::SrcBl:             return {8'b0, tileBytes.bl};
      gpuIsaPkg::SrcSh:             return {8'b0, tileBytes.sh};
      gpuIsaPkg::SrcSl:             return {8'b0, tileBytes.sl};
      gpuIsaPkg::SrcSpriteInfo:     return {8'b0, tileBytes.spriteInfo};
      gpuIsaPkg::SrcR0:             return gpr[0];
      gpuIsaPkg::SrcR1:             return gpr[1];
      gpuIsaPkg::SrcR2:             return gpr[2];
      gpuIsaPkg::SrcR3:             return gpr[3];
      gpuIsaPkg::SrcMapBase:
        return dispRegs.lcdc[gpuVideoPkg::LcdcMapBit] ? gpuVideoPkg::MapBase1 :
                                                       gpuVideoPkg::MapBase0;
      gpuIsaPkg::SrcTileBase:       return tileBase;
      gpuIsaPkg::SrcVmem:           return {8'b0, vmemData};
      gpuIsaPkg::SrcVmemShl4:       return {4'b0, vmemData, 4'b0};
      gpuIsaPkg::SrcScrollTile:     return scrollTile;
      default:                      return '0; // 21..31 unused
    endcase
  endfunction

  always_comb
  begin
    src1Val = srcValue(uop.src1);
    src0Val = srcValue(src0Sel);
    dstVal  = srcValue(uop.dst); // addl/subl read back their target
  end

  //////////////////////////////
  // decode and alu
  //////////////////////////////

  always_comb
  begin
    result    = '0;
    aluOp     = 1'b0;
    jump      = 1'b0;
    readReq   = 1'b0;
    fbWrite   = 1'b0;
    fbAdvance = 1'b0;
    case (uop.op)
      gpuIsaPkg::OpWfbuffer: fbWrite   = 1'b1;
      gpuIsaPkg::OpInfbaddr: fbAdvance = 1'b1;
      gpuIsaPkg::OpRvmem:    readReq   = 1'b1;
      gpuIsaPkg::OpWrr:
      begin
        result = src1Val;
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpWrl:
      begin
        result = {6'b0, uop.lit};
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpAdd:
      begin
        result = src1Val + src0Val;
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpSub:
      begin
        result = src1Val - src0Val;
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpAnd:
      begin
        result = src1Val & src0Val;
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpShl:
      begin
        result = src1Val << uop.lit[5:0]; // 16 and up clears it
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpAddl:
      begin
        result = dstVal + {6'b0, uop.lit};
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpSubl:
      begin
        result = dstVal - {6'b0, uop.lit};
        aluOp  = 1'b1;
      end
      gpuIsaPkg::OpJz:   jump = zeroFlag;
      gpuIsaPkg::OpJnz:  jump = ~zeroFlag;
      gpuIsaPkg::OpGoto: jump = 1'b1;
      default:
      begin
        // nop and the spare encoding do nothing
      end
    endcase
  end

  assign jumpTarget     = uop.lit[7:0];
  assign mcuReadRequest = readReq & active; // no strobe with lcd off

  //////////////////////////////
  // engine registers
  //////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mcuAddr   <= '0;
      tileBytes <= '0;
      zeroFlag  <= 1'b0;
      for (int i = 0; i < 4; i++)
        gpr[i] <= '0;
    end
    else if (aluOp && active) // held uop must not repeat while off
    begin
      zeroFlag <= (result == '0); // flag follows every alu op
      case (uop.dst)
        gpuIsaPkg::SrcMcuAddr:    mcuAddr              <= result;
        gpuIsaPkg::SrcBh:         tileBytes.bh         <= result[7:0];
        gpuIsaPkg::SrcBl:         tileBytes.bl         <= result[7:0];
        gpuIsaPkg::SrcSh:         tileBytes.sh         <= result[7:0];
        gpuIsaPkg::SrcSl:         tileBytes.sl         <= result[7:0];
        gpuIsaPkg::SrcSpriteInfo: tileBytes.spriteInfo <= result[7:0];
        gpuIsaPkg::SrcR0:         gpr[0]               <= result;
        gpuIsaPkg::SrcR1:         gpr[1]               <= result;
        gpuIsaPkg::SrcR2:         gpr[2]               <= result;
        gpuIsaPkg::SrcR3:         gpr[3]               <= result;
        default:
        begin
          // display regs and constants are read only here
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/gpuIsaPkg.sv ====
`default_nettype none

package gpuIsaPkg;

  //////////////////////////////
  // micro-op format
  //////////////////////////////

  localparam int UopWidth  = 24;
  localparam int ProgDepth = 256; // rom words, one per pc value

  typedef logic [UopWidth-1:0] uopT;   // raw rom word
  typedef logic [7:0]          pcT;
  typedef logic [4:0]          srcSelT; // source or destination index
  typedef logic [9:0]          litT;    // literal, top half doubles as src0
  typedef logic [15:0]         wordT;   // engine data path

  typedef enum logic [3:0] {
    OpNop      = 4'd0,
    OpWfbuffer = 4'd1,  // push 8 mixed pixels to frame buffer
    OpInfbaddr = 4'd2,  // bump frame-buffer address
    OpWrr      = 4'd3,
    OpWrl      = 4'd4,
    OpRvmem    = 4'd5,  // read strobe to video memory
    OpAdd      = 4'd6,
    OpSub      = 4'd7,
    OpAnd      = 4'd8,
    OpShl      = 4'd9,
    OpAddl     = 4'd10,
    OpSubl     = 4'd11,
    OpJz       = 4'd12,
    OpJnz      = 4'd13,
    OpGoto     = 4'd14
  } opcodeT;

  typedef struct packed {
    opcodeT op;   // 23:20
    srcSelT dst;  // 19:15
    srcSelT src1; // 14:10
    litT    lit;  // 9:0, src0 lives in 9:5
  } uopFieldsT;

  // engine registers, 0 to 5 are the display registers
  localparam srcSelT SrcMcuAddr    = 5'd6;
  localparam srcSelT SrcBh         = 5'd7;
  localparam srcSelT SrcBl         = 5'd8;
  localparam srcSelT SrcSh         = 5'd9;
  localparam srcSelT SrcSl         = 5'd10;
  localparam srcSelT SrcSpriteInfo = 5'd11;
  localparam srcSelT SrcR0         = 5'd12;
  localparam srcSelT SrcR1         = 5'd13;
  localparam srcSelT SrcR2         = 5'd14;
  localparam srcSelT SrcR3         = 5'd15;

  // read-only constant sources
  localparam srcSelT SrcMapBase    = 5'd16;
  localparam srcSelT SrcTileBase   = 5'd17;
  localparam srcSelT SrcVmem       = 5'd18;
  localparam srcSelT SrcVmemShl4   = 5'd19;
  localparam srcSelT SrcScrollTile = 5'd20;

endpackage

`default_nettype wire

// ==== hw/gpuMcuRegs.sv ====
`default_nettype none

module gpuMcuRegs
(
  input  wire  logic                  clock,
  input  wire  logic                  reset,
  input  wire  gpuVideoPkg::mcuWriteT mcuWrite,
  output gpuVideoPkg::dispRegsT       dispRegs,
  output logic                        gpuActive
);

  //////////////////////////////
  // host write decode
  //////////////////////////////

  // writes land regardless of the engine state
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      dispRegs <= '0;
    end
    else if (mcuWrite.we)
    begin
      case (mcuWrite.regSel)
        gpuVideoPkg::RegLcdc: dispRegs.lcdc <= mcuWrite.data;
        gpuVideoPkg::RegScy:  dispRegs.scy  <= mcuWrite.data;
        gpuVideoPkg::RegScx:  dispRegs.scx  <= mcuWrite.data;
        gpuVideoPkg::RegBgp:  dispRegs.bgp  <= mcuWrite.data;
        gpuVideoPkg::RegObp0: dispRegs.obp0 <= mcuWrite.data;
        gpuVideoPkg::RegObp1: dispRegs.obp1 <= mcuWrite.data;
        default:
        begin
          // selects 6..15 go nowhere
        end
      endcase
    end
  end

  // lcd on bit runs the whole engine
  assign gpuActive = dispRegs.lcdc[gpuVideoPkg::LcdcEnableBit];

endmodule

`default_nettype wire

// ==== hw/gpuPixelMixer.sv ====
`default_nettype none

module gpuPixelMixer
(
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   gpuActive,
  input  wire gpuVideoPkg::dispRegsT  dispRegs,
  input  wire gpuVideoPkg::tileBytesT tileBytes,
  input  wire logic                   fbWrite,
  input  wire logic                   fbAdvance,
  output logic                        fbWe,
  output gpuVideoPkg::fbAddrT         fbAddr,
  output gpuVideoPkg::fbWordT         fbData
);

  gpuVideoPkg::paletteT spritePal;
  gpuVideoPkg::pixelT   bgPix;
  gpuVideoPkg::pixelT   spritePix;

  function automatic gpuVideoPkg::pixelT palLookup(gpuVideoPkg::paletteT pal,
                                                   logic [1:0] idx);
    return pal[2*idx +: 2]; // color n sits at bits 2n+1:2n
  endfunction

  //////////////////////////////
  // 8 pixels in parallel
  //////////////////////////////

  assign spritePal = tileBytes.spriteInfo[gpuVideoPkg::SpritePalBit] ? dispRegs.obp1 :
                                                                      dispRegs.obp0;

  always_comb
  begin
    bgPix     = '0;
    spritePix = '0;
    fbData    = '0;
    for (int i = 0; i < 8; i++)
    begin
      bgPix     = palLookup(dispRegs.bgp, {tileBytes.bh[i], tileBytes.bl[i]});
      spritePix = palLookup(spritePal, {tileBytes.sh[i], tileBytes.sl[i]});
      // sprite wins unless its mapped color is see-through
      fbData[2*i +: 2] = (spritePix == gpuVideoPkg::TransparentColor) ? bgPix : spritePix;
    end
  end

  assign fbWe = fbWrite & gpuActive;

  // frame-buffer write pointer
  always_ff @(posedge clock)
  begin
    if (reset)
      fbAddr <= '0;
    else if (fbAdvance && gpuActive)
      fbAddr <= fbAddr + 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/gpuSequencer.sv ====
`default_nettype none

module gpuSequencer
(
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 gpuActive,
  input  wire logic                 jump,
  input  wire gpuIsaPkg::pcT        jumpTarget,
  output gpuIsaPkg::uopFieldsT      uop
);

  gpuIsaPkg::pcT  pc;
  gpuIsaPkg::uopT rom [gpuIsaPkg::ProgDepth]; // microcode store

  //////////////////////////////
  // microcode rom
  //////////////////////////////

  initial
  begin
    $readmemh("ucode.mem", rom);
  end

  // async read, uop valid in the same cycle as pc
  assign uop = gpuIsaPkg::uopFieldsT'(rom[pc]);

  //////////////////////////////
  // program counter
  //////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc <= '0;
    end
    else if (gpuActive)
    begin
      if (jump)
        pc <= jumpTarget;                 // taken branch
      else
        pc <= gpuIsaPkg::pcT'(pc + 1'b1); // wraps at ProgDepth
    end
    // lcd off holds pc, resumes from here
  end

endmodule

`default_nettype wire

// ==== hw/gpuVideoPkg.sv ====
`default_nettype none

package gpuVideoPkg;

  typedef logic [1:0]  pixelT;   // 2-bit color
  typedef logic [7:0]  paletteT; // four pixelT fields, color 0 in bits 1:0
  typedef logic [3:0]  regSelT;  // host register select
  typedef logic [15:0] fbAddrT;
  typedef logic [15:0] fbWordT;  // 8 pixels, pixel 0 in bits 1:0

  //////////////////////////////
  // host registers
  //////////////////////////////

  localparam regSelT RegLcdc = 4'd0;
  localparam regSelT RegScy  = 4'd1;
  localparam regSelT RegScx  = 4'd2;
  localparam regSelT RegBgp  = 4'd3;
  localparam regSelT RegObp0 = 4'd4;
  localparam regSelT RegObp1 = 4'd5;

  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    paletteT    bgp;
    paletteT    obp0;
    paletteT    obp1;
  } dispRegsT;

  typedef struct packed {
    logic       we;
    regSelT     regSel;
    logic [7:0] data;
  } mcuWriteT;

  typedef struct packed {
    logic [7:0] bh;         // tile bitplanes
    logic [7:0] bl;
    logic [7:0] sh;         // sprite bitplanes
    logic [7:0] sl;
    logic [7:0] spriteInfo; // attribute byte
  } tileBytesT;

  // video memory map
  localparam logic [15:0] MapBase0       = 16'h9800;
  localparam logic [15:0] MapBase1       = 16'h9C00;
  localparam logic [15:0] TileBase0      = 16'h9000; // signed tile index
  localparam logic [15:0] TileBase1      = 16'h8000; // negative index lands here
  localparam logic [15:0] TileBaseShared = 16'h8000;

  localparam int LcdcEnableBit = 7;
  localparam int LcdcMapBit    = 6;
  localparam int LcdcTileBit   = 4;
  localparam int SpritePalBit  = 4; // in spriteInfo, selects obp1

  localparam pixelT TransparentColor = 2'd0;

endpackage

`default_nettype wire

// ==== tb/gpuCoreTb.sv ====
`default_nettype none

module gpuCoreTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles   = 10;
  localparam int RunCycles     = 2000;
  localparam int FreezeAt      = 1000;                      // lcd off in mid-run
  localparam int FreezeCycles  = 40;
  localparam int TimeoutCycles = RunCycles + RunCycles / 4; // run plus reset and setup

  logic                  clock;
  logic                  reset;
  logic                  mcuWe;
  gpuVideoPkg::regSelT   mcuRegSel;
  logic [7:0]            mcuWriteData;
  logic [7:0]            vmemData;
  gpuIsaPkg::wordT       mcuAddr;
  logic                  mcuReadRequest;
  logic                  fbWe;
  gpuVideoPkg::fbAddrT   fbAddr;
  gpuVideoPkg::fbWordT   fbData;

  logic [31:0] seed;
  int          errors;
  int          checks;
  int          assertFails;
  int          cycleCount;
  logic        readSeen = 1'b0;  // model saw rvmem in the last cycle

  // model state
  logic [23:0] prog [256];
  logic [7:0]  dispReg [6];      // lcdc scy scx bgp obp0 obp1
  logic [15:0] engReg [16];      // 6..15 used
  logic [7:0]  mPc;
  logic [15:0] mFbAddr;
  logic        mZero;

  gpuCore DUT
  (
    .clock          (clock),
    .reset          (reset),
    .mcuWe          (mcuWe),
    .mcuRegSel      (mcuRegSel),
    .mcuWriteData   (mcuWriteData),
    .vmemData       (vmemData),
    .mcuAddr        (mcuAddr),
    .mcuReadRequest (mcuReadRequest),
    .fbWe           (fbWe),
    .fbAddr         (fbAddr),
    .fbData         (fbData)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //////////////////////////////
  // instruction-set model
  //////////////////////////////

  function automatic logic [15:0] sourceValue(input logic [4:0] sel);
    logic [15:0] rowBase;
    if (sel < 5'd6)
      return {8'h00, dispReg[sel]};
    if (sel < 5'd16)
      return engReg[sel];
    rowBase = {8'h00, dispReg[1]} / 16'd8;
    case (sel)
      gpuIsaPkg::SrcMapBase:    return dispReg[0][6] ? 16'h9C00 : 16'h9800;
      gpuIsaPkg::SrcTileBase:
        return dispReg[0][4] ? 16'h8000 : (vmemData[7] ? 16'h8000 : 16'h9000);
      gpuIsaPkg::SrcVmem:       return {8'h00, vmemData};
      gpuIsaPkg::SrcVmemShl4:   return {4'h0, vmemData, 4'h0};
      gpuIsaPkg::SrcScrollTile: return rowBase * 16'd32 + {8'h00, dispReg[2]};
      default:                  return 16'h0000;
    endcase
  endfunction

  // strobe of the uop the model sits on, lcd on only
  function automatic logic expectedStrobe(input logic [3:0] opWanted);
    return dispReg[0][7] && (prog[mPc][23:20] == opWanted);
  endfunction

  function automatic logic [15:0] mixPixels();
    logic [15:0] word;
    logic [7:0]  sprPal;
    logic [1:0]  bgIdx;
    logic [1:0]  spIdx;
    logic [1:0]  bgCol;
    logic [1:0]  spCol;
    word   = 16'h0000;
    sprPal = engReg[gpuIsaPkg::SrcSpriteInfo][4] ? dispReg[5] : dispReg[4]; // obp1 : obp0
    for (int i = 0; i < 8; i++)
    begin
      bgIdx = {engReg[gpuIsaPkg::SrcBh][i], engReg[gpuIsaPkg::SrcBl][i]};
      spIdx = {engReg[gpuIsaPkg::SrcSh][i], engReg[gpuIsaPkg::SrcSl][i]};
      bgCol = 2'(dispReg[3] >> (2 * bgIdx));
      spCol = 2'(sprPal >> (2 * spIdx));
      word[2*i +: 2] = (spCol == 2'd0) ? bgCol : spCol; // color 0 sprite is see-through
    end
    return word;
  endfunction

  always @(posedge clock)
  begin : isaModel
    logic [3:0]  op;
    logic [4:0]  dst;
    logic [9:0]  lit;
    logic [15:0] src1Val;
    logic [15:0] src0Val;
    logic [15:0] res;
    logic        aluOp;
    logic        jmp;
    readSeen = !reset && expectedStrobe(gpuIsaPkg::OpRvmem);
    if (reset)
    begin
      mPc     = 8'h00;
      mFbAddr = 16'h0000;
      mZero   = 1'b0;
      for (int i = 0; i < 6; i++)
        dispReg[i] = 8'h00;
      for (int i = 0; i < 16; i++)
        engReg[i] = 16'h0000;
    end
    else
    begin
      if (dispReg[0][7])
      begin
        op      = prog[mPc][23:20];
        dst     = prog[mPc][19:15];
        lit     = prog[mPc][9:0];
        src1Val = sourceValue(prog[mPc][14:10]);
        src0Val = sourceValue(prog[mPc][9:5]);
        res     = 16'h0000;
        aluOp   = 1'b1;
        jmp     = 1'b0;
        case (op)
          gpuIsaPkg::OpWrr:  res = src1Val;
          gpuIsaPkg::OpWrl:  res = {6'h00, lit};
          gpuIsaPkg::OpAdd:  res = src1Val + src0Val;
          gpuIsaPkg::OpSub:  res = src1Val - src0Val;
          gpuIsaPkg::OpAnd:  res = src1Val & src0Val;
          gpuIsaPkg::OpShl:  res = src1Val << lit[5:0];
          gpuIsaPkg::OpAddl: res = sourceValue(dst) + {6'h00, lit};
          gpuIsaPkg::OpSubl: res = sourceValue(dst) - {6'h00, lit};
          default:           aluOp = 1'b0;
        endcase
        if (op == gpuIsaPkg::OpInfbaddr)
          mFbAddr = mFbAddr + 16'd1;
        if (op == gpuIsaPkg::OpJz)
          jmp = mZero;
        if (op == gpuIsaPkg::OpJnz)
          jmp = !mZero;
        if (op == gpuIsaPkg::OpGoto)
          jmp = 1'b1;
        if (aluOp)
        begin
          mZero = (res == 16'h0000);
          if (dst >= gpuIsaPkg::SrcBh && dst <= gpuIsaPkg::SrcSpriteInfo)
            engReg[dst] = {8'h00, res[7:0]};  // byte-wide tile regs
          else if (dst >= gpuIsaPkg::SrcMcuAddr && dst <= gpuIsaPkg::SrcR3)
            engReg[dst] = res;
        end
        mPc = jmp ? lit[7:0] : mPc + 8'd1;
      end
      // host write lands after the step, same edge
      if (mcuWe && mcuRegSel <= gpuVideoPkg::RegObp1)
        dispReg[mcuRegSel] = mcuWriteData;
    end
  end

  //////////////////////////////
  // checks and stimulus
  //////////////////////////////

  task automatic compareValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkOutputs();
    compareValue("mcuReadRequest", 16'(mcuReadRequest), 16'(expectedStrobe(gpuIsaPkg::OpRvmem)));
    compareValue("mcuAddr", mcuAddr, engReg[gpuIsaPkg::SrcMcuAddr]);
    compareValue("fbWe", 16'(fbWe), 16'(expectedStrobe(gpuIsaPkg::OpWfbuffer)));
    compareValue("fbAddr", fbAddr, mFbAddr);
    if (expectedStrobe(gpuIsaPkg::OpWfbuffer))
      compareValue("fbData", fbData, mixPixels());
  endtask

  function automatic logic [7:0] randomByte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // one falling edge: check, then refresh vram data after a read
  task automatic advanceCycle();
    @(negedge clock);
    mcuWe = 1'b0;
    if (!reset)
      checkOutputs();
    if (readSeen)
      vmemData = randomByte();
  endtask

  task automatic driveHostWrite(input gpuVideoPkg::regSelT sel, input logic [7:0] data);
    mcuWe        = 1'b1;
    mcuRegSel    = sel;
    mcuWriteData = data;
  endtask

  task automatic writeHostReg(input gpuVideoPkg::regSelT sel, input logic [7:0] data);
    advanceCycle();
    driveHostWrite(sel, data);
  endtask

  initial
  begin
    $readmemh("ucode.mem", prog);
    seed         = 32'h44a1;
    errors       = 0;
    checks       = 0;
    reset        = 1'b1;
    mcuWe        = 1'b0;
    mcuRegSel    = '0;
    mcuWriteData = 8'h00;
    vmemData     = 8'h00;
    repeat (ResetCycles) @(negedge clock);
    reset = 1'b0;

    writeHostReg(gpuVideoPkg::RegBgp, randomByte());
    writeHostReg(gpuVideoPkg::RegObp0, randomByte());
    writeHostReg(gpuVideoPkg::RegObp1, randomByte());
    writeHostReg(gpuVideoPkg::RegScy, randomByte());
    writeHostReg(gpuVideoPkg::RegScx, randomByte());
    writeHostReg(gpuVideoPkg::RegLcdc, randomByte() & 8'h7f); // lcd still off
    repeat (8) advanceCycle();                                  // strobes must stay quiet
    driveHostWrite(gpuVideoPkg::RegLcdc, (randomByte() | 8'h80) & 8'hef); // signed tile base

    for (int n = 0; n < RunCycles; n++)
    begin
      advanceCycle();
      if (n == FreezeAt)
        driveHostWrite(gpuVideoPkg::RegLcdc, randomByte() & 8'h7f);
      else if (n == FreezeAt + FreezeCycles)
        driveHostWrite(gpuVideoPkg::RegLcdc, randomByte() | 8'h90); // shared tile base
    end
    advanceCycle();

    assertFails = DUT.coreChecker.failCount;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assertFails);
    if (errors == 0 && assertFails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // hang guard
  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge clock);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the run did not reach its end", cycleCount);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/gpuCore_checker.sv ====
`default_nettype none

module gpuCoreChecker
(
  input wire logic                clock,
  input wire logic                reset,
  input wire logic                fbWe,
  input wire logic                mcuReadRequest,
  input wire gpuVideoPkg::fbAddrT fbAddr
);

  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;

  //////////////////////////////
  // output strobes
  //////////////////////////////

  // one uop per cycle, so never both
  strobesExclusive: assert property (@(posedge clock) disable iff (reset)
    !(fbWe && mcuReadRequest))
    else
    begin
      failCount++;
      $error("fbWe and mcuReadRequest high in the same cycle");
    end

  // regs settle one edge into reset
  strobesQuietInReset: assert property (@(posedge clock)
    reset && $past(reset) |-> !fbWe && !mcuReadRequest)
    else
    begin
      failCount++;
      $error("strobe high while reset is held");
    end

  fbAddrStepsByOne: assert property (@(posedge clock) disable iff (reset)
    $changed(fbAddr) |-> fbAddr == $past(fbAddr) + 16'd1)
    else
    begin
      failCount++;
      $error("fbAddr moved by something other than +1");
    end

endmodule

bind gpuCore gpuCoreChecker coreChecker
(
  .clock          (clock),
  .reset          (reset),
  .fbWe           (fbWe),
  .mcuReadRequest (mcuReadRequest),
  .fbAddr         (fbAddr)
);

`default_nettype wire

// ==== ucode.mem ====
// one 24-bit micro-op per line, hex: op[23:20] dst[19:15] src1[14:10] src0/lit[9:0]
// word index = pc, starting at 0
478003  // 00 wrl  r3 <- 3, tiles per pass
335000  // 01 wrr  mcuAddr <- scrollTile
631A00  // 02 add  mcuAddr <- mcuAddr + mapBase
500000  // 03 rvmem tile number
364400  // 04 wrr  r0 <- tileBase, bit 7 of vram picks half
36CC00  // 05 wrr  r1 <- vram << 4
6331A0  // 06 add  mcuAddr <- r0 + r1
500000  // 07 rvmem
33C800  // 08 wrr  bh <- vram
A30001  // 09 addl mcuAddr += 1
500000  // 0a rvmem
344800  // 0b wrr  bl <- vram
A30010  // 0c addl mcuAddr += 16, sprite row
500000  // 0d rvmem
34C800  // 0e wrr  sh <- vram
500000  // 0f rvmem
354800  // 10 wrr  sl <- vram
B30002  // 11 subl mcuAddr -= 2
500000  // 12 rvmem
35C800  // 13 wrr  spriteInfo <- vram
100000  // 14 wfbuffer
200000  // 15 infbaddr
8748E0  // 16 and  r2 <- vram & bh
C00019  // 17 jz   0x19
96B401  // 18 shl  r1 <- r1 << 1
773580  // 19 sub  r2 <- r1 - r0
B78001  // 1a subl r3 -= 1
D00001  // 1b jnz  0x01
000000  // 1c nop
E00000  // 1d goto 0x00
